// File: filelist.f
stream_pkg.sv
dti.sv
decouple.sv
delta_encoder.sv
checksum_append.sv
delta_stream_top.sv
tb_delta_stream_asserts.sv
tb_delta_stream.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the delta stream testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_delta_stream -f filelist.f
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/Vtb_delta_stream > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation finished: FAIL" "$log"; then
    echo "Testbench reported failure"
    exit 1
fi

if ! grep -q "Simulation finished: PASS" "$log"; then
    echo "Testbench did not report a result"
    exit 1
fi

exit 0

// File: tb_delta_stream.sv
`timescale 1ns/1ps

module tb_delta_stream;

    localparam int clk_half     = 4;
    localparam int reset_len    = 10;
    localparam int max_words    = 90;   // Upper bound on words over all tests
    localparam int cyc_per_word = 200;

    logic                clk;
    logic                rst;
    stream_pkg::sample_t in_data;
    logic                in_last;
    logic                in_valid;
    logic                in_ready;
    stream_pkg::sample_t out_data;
    logic                out_last;
    logic                out_valid;
    logic                out_ready;

    integer seed;
    int     ready_mode;     // 0 low, 1 high, 2 random stretches
    int     stretch_left;
    logic   stretch_level;
    int     stall_run;
    logic   stall_seen;

    stream_pkg::sample_t pkt_q[$];
    stream_pkg::sample_t tx_data_q[$];
    logic                tx_last_q[$];
    stream_pkg::sample_t exp_data_q[$];
    logic                exp_last_q[$];

    delta_stream_top dut0 (
        .clk       (clk),
        .rst       (rst),
        .in_data   (in_data),
        .in_last   (in_last),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_data  (out_data),
        .out_last  (out_last),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    bind delta_stream_top tb_delta_stream_asserts u_asserts (
        .clk       (clk),
        .rst       (rst),
        .in_ready  (in_ready),
        .out_data  (out_data),
        .out_last  (out_last),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    always #(clk_half) clk = ~clk;

    function automatic int rand_below(input int n);
        return int'({$random(seed)} % n);
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic compare_sample(input stream_pkg::sample_t got, input stream_pkg::sample_t exp,
                                  input string what);
        if (got !== exp) begin
            report_failure($sformatf("MISMATCH at %0t ns: %s data %h, expected %h",
                                     $time, what, got, exp));
        end
    endtask

    task automatic compare_last(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            report_failure($sformatf("MISMATCH at %0t ns: %s last %b, expected %b",
                                     $time, what, got, exp));
        end
    endtask

    // Reference model gives the raw first sample, then differences, then the packet sum
    function automatic void add_packet();
        stream_pkg::sample_t word;
        stream_pkg::csum_t   sum;
        sum = '0;
        foreach (pkt_q[i]) begin
            tx_data_q.push_back(pkt_q[i]);
            tx_last_q.push_back(i == pkt_q.size() - 1);
            if (i == 0) begin
                word = pkt_q[i];
            end else begin
                word = stream_pkg::sample_t'(pkt_q[i] - pkt_q[i-1]);    // Wraps modulo 2^16
            end
            sum = stream_pkg::csum_t'(sum + stream_pkg::csum_t'(word));
            exp_data_q.push_back(word);
            exp_last_q.push_back(1'b0);
        end
        exp_data_q.push_back(stream_pkg::sample_t'(sum));
        exp_last_q.push_back(1'b1);                                     // Checksum closes packet
        pkt_q.delete();
    endfunction

    task automatic check_output();
        stream_pkg::sample_t exp_data;
        logic                exp_last;
        if (exp_data_q.size() == 0) begin
            report_failure($sformatf("Unexpected output word %h at %0t ns, nothing was expected",
                                     out_data, $time));
        end else begin
            exp_data = exp_data_q.pop_front();
            exp_last = exp_last_q.pop_front();
            compare_sample(out_data, exp_data, "output");
            compare_last(out_last, exp_last, "output");
        end
    endtask

    // Output ready pattern and monitor for the word that moves at the next rising edge
    always @(negedge clk) begin
        case (ready_mode)
            0: out_ready = 1'b0;
            1: out_ready = 1'b1;
            default: begin
                if (stretch_left == 0) begin
                    stretch_level = (rand_below(2) == 1);
                    stretch_left  = 1 + (stretch_level ? rand_below(6) : rand_below(24));
                end
                stretch_left--;
                out_ready = stretch_level;
            end
        endcase
        if (out_valid === 1'b1 && out_ready) begin
            check_output();
        end
    end

    task automatic set_ready_mode(input int mode);
        @(posedge clk);
        ready_mode = mode;
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst      = 1'b1;
        in_valid = 1'b0;
        in_last  = 1'b0;
        repeat (reset_len) @(negedge clk);
        rst = 1'b0;
    endtask

    // in_ready is registered, so its value at the falling edge decides the transfer
    task automatic drive_stream(input int idle_pct);
        logic ready_seen;
        while (tx_data_q.size() > 0) begin
            @(negedge clk);
            if (rand_below(100) < idle_pct) begin
                in_valid = 1'b0;
                in_last  = 1'b0;
            end else begin
                in_valid   = 1'b1;
                in_data    = tx_data_q.pop_front();
                in_last    = tx_last_q.pop_front();
                ready_seen = in_ready;
                stall_run  = 0;
                while (!ready_seen) begin
                    stall_run++;
                    if (stall_run >= 4) begin
                        stall_seen = 1'b1;
                    end
                    @(negedge clk);
                    ready_seen = in_ready;
                end
            end
        end
        @(negedge clk);
        in_valid = 1'b0;
        in_last  = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_data_q.size() > 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
    endtask

    task automatic test_single_packet();
        $display("Running test_single_packet");
        set_ready_mode(1);
        pkt_q = '{16'h1000, 16'h1005, 16'h0ffa, 16'h2000, 16'h1fff};
        add_packet();
        drive_stream(0);
        wait_drain();
    endtask

    task automatic test_one_word_packet();
        $display("Running test_one_word_packet");
        set_ready_mode(1);
        pkt_q.push_back(16'hbeef);
        add_packet();
        drive_stream(0);
        wait_drain();
    endtask

    task automatic test_wraparound();
        $display("Running test_wraparound");
        set_ready_mode(1);
        pkt_q = '{16'h0002, 16'hfffe, 16'h0001, 16'h8000, 16'h7fff};
        add_packet();
        drive_stream(0);
        wait_drain();
    endtask

    task automatic test_backpressure();
        int len;
        $display("Running test_backpressure");
        stall_seen = 1'b0;
        set_ready_mode(0);
        for (int p = 0; p < 3; p++) begin
            len = 1 + rand_below(12);
            for (int i = 0; i < len; i++) begin
                pkt_q.push_back(stream_pkg::sample_t'($random(seed)));
            end
            add_packet();
        end
        fork
            drive_stream(20);
            begin
                repeat (30) @(posedge clk);     // Long stall fills FIFO and stages
                set_ready_mode(2);
            end
        join
        wait_drain();
        if (!stall_seen) begin
            report_failure("in_ready never stayed low while the output was stalled");
        end
        set_ready_mode(1);
    endtask

    task automatic test_back_to_back();
        $display("Running test_back_to_back");
        set_ready_mode(1);
        pkt_q = '{16'h0010, 16'h0020, 16'h0040, 16'h0030};
        add_packet();
        pkt_q.push_back(stream_pkg::sample_t'($random(seed)));
        add_packet();
        for (int i = 0; i < 6; i++) begin
            pkt_q.push_back(stream_pkg::sample_t'($random(seed)));
        end
        add_packet();
        drive_stream(0);                        // in_valid stays high across packets
        wait_drain();
    endtask

    task automatic test_reset_recovery();
        $display("Running test_reset_recovery");
        set_ready_mode(0);
        for (int i = 0; i < 3; i++) begin
            tx_data_q.push_back(stream_pkg::sample_t'($random(seed)));
            tx_last_q.push_back(1'b0);          // Partial packet that is never completed
        end
        drive_stream(0);
        repeat (3) @(posedge clk);
        apply_reset();
        exp_data_q.delete();
        exp_last_q.delete();
        set_ready_mode(1);
        pkt_q = '{16'h0100, 16'h0180, 16'h0050, 16'hfff0};
        add_packet();
        drive_stream(0);
        wait_drain();
    endtask

    initial begin
        repeat (max_words * cyc_per_word + 2 * reset_len) @(posedge clk);
        report_failure("Timeout: the tests did not complete in the allowed number of cycles");
    end

    initial begin
        seed          = 32'h634c9154;
        clk           = 1'b0;
        rst           = 1'b1;
        in_data       = '0;
        in_last       = 1'b0;
        in_valid      = 1'b0;
        out_ready     = 1'b0;
        ready_mode    = 0;
        stretch_left  = 0;
        stretch_level = 1'b0;
        stall_run     = 0;
        stall_seen    = 1'b0;

        apply_reset();
        test_single_packet();
        test_one_word_packet();
        test_wraparound();
        test_backpressure();
        test_back_to_back();
        test_reset_recovery();

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule : tb_delta_stream

// File: tb_delta_stream_asserts.sv
`timescale 1ns/1ps

module tb_delta_stream_asserts (
    input logic                clk,
    input logic                rst,
    input logic                in_ready,
    input stream_pkg::sample_t out_data,
    input logic                out_last,
    input logic                out_valid,
    input logic                out_ready
);

    // Registers are cleared one edge after rst is seen
    property p_out_valid_low_after_reset;
        @(posedge clk) rst |=> !out_valid;
    endproperty

    // Stalled output word holds still
    property p_out_stable_when_stalled;
        @(posedge clk) disable iff (rst)
            (out_valid && !out_ready) |=> (out_valid && $stable(out_data) && $stable(out_last));
    endproperty

    property p_in_ready_low_in_reset;
        @(posedge clk) rst |=> !in_ready;
    endproperty

    a_out_valid_low_after_reset : assert property (p_out_valid_low_after_reset)
        else $error("out_valid high during or right after reset");

    a_out_stable_when_stalled : assert property (p_out_stable_when_stalled)
        else $error("out_data or out_last changed while the output was stalled");

    a_in_ready_low_in_reset : assert property (p_in_ready_low_in_reset)
        else $error("in_ready high during reset");

endmodule : tb_delta_stream_asserts

// File: delta_stream_top.sv
`timescale 1ns/1ps

module delta_stream_top (
    input  logic                clk,
    input  logic                rst,
    input  stream_pkg::sample_t in_data,
    input  logic                in_last,
    input  logic                in_valid,
    output logic                in_ready,
    output stream_pkg::sample_t out_data,
    output logic                out_last,
    output logic                out_valid,
    input  logic                out_ready
);

    dti s_in ();
    dti s_reg ();
    dti s_enc ();
    dti s_csum ();
    dti s_out ();

    assign s_in.data  = in_data;
    assign s_in.last  = in_last;
    assign s_in.valid = in_valid;
    assign in_ready   = s_in.ready;

    decouple #(
        .DEPTH (stream_pkg::in_depth)
    ) u_in_slice (
        .clk  (clk),
        .rst  (rst),
        .din  (s_in),
        .dout (s_reg)
    );

    delta_encoder u_delta (
        .clk  (clk),
        .rst  (rst),
        .din  (s_reg),
        .dout (s_enc)
    );

    checksum_append u_csum (
        .clk  (clk),
        .rst  (rst),
        .din  (s_enc),
        .dout (s_csum)
    );

    decouple #(
        .DEPTH (stream_pkg::out_depth)
    ) u_out_fifo (
        .clk  (clk),
        .rst  (rst),
        .din  (s_csum),
        .dout (s_out)
    );

    assign out_data    = s_out.data;
    assign out_last    = s_out.last;
    assign out_valid   = s_out.valid;
    assign s_out.ready = out_ready;

endmodule : delta_stream_top

// File: checksum_append.sv
`timescale 1ns/1ps

module checksum_append (
    input logic  clk,
    input logic  rst,
    dti.consumer din,
    dti.producer dout
);

    stream_pkg::csum_t sum_q;   // Running sum that holds the final sum while inserting
    stream_pkg::csum_t sum_nxt;
    logic              ins_q;   // Checksum word pending
    logic              in_xfer;
    logic              csum_xfer;

    assign sum_nxt = sum_q + stream_pkg::csum_t'(din.data);

    assign in_xfer   = din.valid && din.ready;
    assign csum_xfer = ins_q && dout.ready;

    // Input stalls while the checksum word is out
    assign din.ready  = dout.ready && !ins_q;
    assign dout.valid = ins_q || din.valid;
    assign dout.data  = ins_q ? stream_pkg::sample_t'(sum_q) : din.data;
    assign dout.last  = ins_q;  // Only the checksum word closes a packet

    always_ff @(posedge clk) begin
        if (rst) begin
            ins_q <= 1'b0;
            sum_q <= '0;
        end else if (csum_xfer) begin
            ins_q <= 1'b0;
            sum_q <= '0;
        end else if (in_xfer) begin
            sum_q <= sum_nxt;
            if (din.last) begin
                ins_q <= 1'b1;
            end
        end
    end

endmodule : checksum_append

// File: delta_encoder.sv
`timescale 1ns/1ps

module delta_encoder (
    input logic  clk,
    input logic  rst,
    dti.consumer din,
    dti.producer dout
);

    stream_pkg::sample_t prev_q;    // Previous raw sample of this packet
    logic                first_q;   // Next word opens a packet
    logic                xfer;

    assign xfer = din.valid && dout.ready;

    // Handshake passes straight through
    assign dout.valid = din.valid;
    assign din.ready  = dout.ready;
    assign dout.last  = din.last;

    // First word raw, later words as modulo 2^16 differences
    assign dout.data = first_q ? din.data : stream_pkg::sample_t'(din.data - prev_q);

    always_ff @(posedge clk) begin
        if (rst) begin
            first_q <= 1'b1;
        end else if (xfer) begin
            first_q <= din.last;
        end
    end

    always_ff @(posedge clk) begin
        if (xfer) begin
            prev_q <= din.data;
        end
    end

endmodule : delta_encoder

// File: decouple.sv
`timescale 1ns/1ps

module decouple #(
    parameter int DEPTH = 2
) (
    input logic  clk,
    input logic  rst,
    dti.consumer din,
    dti.producer dout
);

    if (DEPTH == 1) begin : g_slice

        stream_pkg::sample_t data_q;
        logic                last_q;
        logic                valid_q;
        logic                valid_nxt;
        logic                ready_q;   // Low through reset, then tracks empty

        always_comb begin
            valid_nxt = valid_q;
            if (valid_q && dout.ready) begin
                valid_nxt = 1'b0;                   // Word taken downstream
            end else if (!valid_q && ready_q && din.valid) begin
                valid_nxt = 1'b1;                   // Load into empty slice
            end
        end

        always_ff @(posedge clk) begin
            if (rst) begin
                valid_q <= 1'b0;
                ready_q <= 1'b0;
            end else begin
                valid_q <= valid_nxt;
                ready_q <= !valid_nxt;
            end
        end

        always_ff @(posedge clk) begin
            if (din.valid && ready_q) begin
                data_q <= din.data;
                last_q <= din.last;
            end
        end

        assign din.ready  = ready_q;
        assign dout.data  = data_q;
        assign dout.last  = last_q;
        assign dout.valid = valid_q;

    end else begin : g_fifo

        localparam int aw = $clog2(DEPTH);

        // Entry layout is {last, data}
        logic [stream_pkg::sample_w:0] mem [DEPTH];
        logic [aw:0]                   wr_ptr;
        logic [aw:0]                   rd_ptr;
        logic                          empty;
        logic                          full;
        logic                          wr_en;
        logic                          rd_en;

        assign empty = (wr_ptr == rd_ptr);
        assign full  = (wr_ptr[aw-1:0] == rd_ptr[aw-1:0]) && (wr_ptr[aw] != rd_ptr[aw]);

        assign wr_en = din.valid && !full;
        assign rd_en = dout.ready && !empty;

        always_ff @(posedge clk) begin
            if (rst) begin
                wr_ptr <= '0;
            end else if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end

        always_ff @(posedge clk) begin
            if (rst) begin
                rd_ptr <= '0;
            end else if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end

        always_ff @(posedge clk) begin
            if (wr_en) begin
                mem[wr_ptr[aw-1:0]] <= {din.last, din.data};
            end
        end

        // Head entry read straight from the array
        assign dout.data  = mem[rd_ptr[aw-1:0]][stream_pkg::sample_w-1:0];
        assign dout.last  = mem[rd_ptr[aw-1:0]][stream_pkg::sample_w];
        assign dout.valid = !empty;
        assign din.ready  = !full;

    end

endmodule : decouple

// File: dti.sv
`timescale 1ns/1ps

interface dti;

    stream_pkg::sample_t data;
    logic                last;  // Marks the final word of a packet
    logic                valid;
    logic                ready;

    modport producer (
        output data,
        output last,
        output valid,
        input  ready
    );

    modport consumer (
        input  data,
        input  last,
        input  valid,
        output ready
    );

endinterface : dti

// File: stream_pkg.sv
package stream_pkg;

    // Sample path
    localparam int sample_w = 16;

    // Raw samples and encoded words share one width
    typedef logic [sample_w-1:0] sample_t;

    // Running packet sum that wraps modulo 2^16
    typedef logic [sample_w-1:0] csum_t;

    // Buffer depths
    localparam int in_depth  = 1;   // Single register slice
    localparam int out_depth = 4;   // Circular FIFO with a power-of-two depth

endpackage : stream_pkg
